// ==== src/fpuPkg.sv ====
// Single precision only (FLEN = XLEN = 32), no NaN-boxing, no rounding modes, only NV is ever set
package fpuPkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int FLEN = 32;             // FP word, also the integer word
  localparam int NE   = 8;              // Exponent bits
  localparam int NF   = 23;             // Fraction bits

  typedef logic [FLEN-1:0] fpWord_t;    // FP register value
  typedef logic [FLEN-1:0] intWord_t;   // Integer operand or result
  typedef logic [4:0]      regAddr_t;   // Register number
  typedef logic [31:0]     instr_t;     // Raw instruction
  typedef logic [4:0]      fflags_t;    // NV DZ OF UF NX, NV in bit 4

  ////////////////////
  // Encodings
  ////////////////////
  localparam logic [6:0] OP_FP       = 7'b1010011;   // OP-FP major opcode
  localparam logic [6:0] F7_SGNJ     = 7'b0010000;   // fsgnj.s group
  localparam logic [6:0] F7_MINMAX   = 7'b0010100;   // fmin.s / fmax.s
  localparam logic [6:0] F7_CMP      = 7'b1010000;   // feq / flt / fle
  localparam logic [6:0] F7_MVXCLASS = 7'b1110000;   // fmv.x.w and fclass.s
  localparam logic [6:0] F7_MVWX     = 7'b1111000;   // fmv.w.x

  localparam fpWord_t CANON_NAN = 32'h7FC00000;      // Canonical quiet NaN

  // Operation class carried down the pipe
  typedef enum logic [2:0] {
    OP_SGNJ,
    OP_MINMAX,
    OP_CMP,
    OP_MVXW,
    OP_CLASS,
    OP_MVWX
  } opClass_t;

  // Decode to execute control
  typedef struct packed {
    logic     valid;        // Legal instruction in execute
    opClass_t op;
    logic [2:0] funct3;     // Selects variant within group
    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;
    logic     writesFp;     // Result goes to FP register file
    logic     writesInt;    // Result goes out on intResult
    intWord_t intSrc;       // Integer operand for fmv.w.x
  } fpCtrl_t;

  // Unpacked operand with class bits
  typedef struct packed {
    logic          sign;
    logic [NE-1:0] exp;
    logic [NF-1:0] frac;
    logic          isZero;
    logic          isInf;
    logic          isNaN;
    logic          isSNaN;     // NaN with quiet bit clear
    logic          isSubnorm;
  } fpParts_t;

endpackage

// ==== src/fpuDecoder.sv ====
// OP-FP single precision only; rm field is a plain funct3 selector, illegal ops never reach execute
`timescale 1ns/10ps

module fpuDecoder (
  input  logic             clk,
  input  logic             rst,
  input  logic             instrValid,
  input  fpuPkg::instr_t   instr,
  input  fpuPkg::intWord_t intSrc,
  output fpuPkg::regAddr_t rs1,
  output fpuPkg::regAddr_t rs2,
  output fpuPkg::fpCtrl_t  ctrlE,
  output logic             illegalE
);

  logic [6:0]       opcode, funct7;
  logic [2:0]       funct3;
  logic             legal;                // Instruction in the supported set
  logic             writesFp, writesInt;
  fpuPkg::opClass_t op;

  // Field split
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];           // Straight to register file read ports
  assign rs2    = instr[24:20];

  ////////////////////
  // Legality and op class
  ////////////////////
  always_comb begin
    legal     = 1'b0;
    op        = fpuPkg::OP_SGNJ;
    writesFp  = 1'b0;
    writesInt = 1'b0;
    if (opcode == fpuPkg::OP_FP) begin
      case (funct7)
        fpuPkg::F7_SGNJ: begin
          legal    = (funct3 <= 3'd2);    // fsgnj, fsgnjn, fsgnjx
          writesFp = 1'b1;
        end
        fpuPkg::F7_MINMAX: begin
          legal    = (funct3 <= 3'd1);    // fmin, fmax
          op       = fpuPkg::OP_MINMAX;
          writesFp = 1'b1;
        end
        fpuPkg::F7_CMP: begin
          legal     = (funct3 <= 3'd2);   // fle, flt, feq
          op        = fpuPkg::OP_CMP;
          writesInt = 1'b1;
        end
        fpuPkg::F7_MVXCLASS: begin
          legal     = (funct3 <= 3'd1) && (rs2 == 5'd0);
          op        = funct3[0] ? fpuPkg::OP_CLASS : fpuPkg::OP_MVXW;
          writesInt = 1'b1;
        end
        fpuPkg::F7_MVWX: begin
          legal    = (funct3 == 3'd0) && (rs2 == 5'd0);
          op       = fpuPkg::OP_MVWX;
          writesFp = 1'b1;
        end
        default: legal = 1'b0;            // Everything else, incl. arithmetic
      endcase
    end
  end

  // Decode/execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlE    <= '0;
      illegalE <= 1'b0;
    end else begin
      ctrlE.valid     <= instrValid & legal;
      ctrlE.op        <= op;
      ctrlE.funct3    <= funct3;
      ctrlE.rs1       <= rs1;
      ctrlE.rs2       <= rs2;
      ctrlE.rd        <= instr[11:7];
      ctrlE.writesFp  <= writesFp;
      ctrlE.writesInt <= writesInt;
      ctrlE.intSrc    <= intSrc;      // Sampled with the instruction
      illegalE        <= instrValid & ~legal;
    end
  end

endmodule

// ==== src/fpRegFile.sv ====
// 32 FP registers, f0 is writable; same-edge write bypasses into the registered read data
`timescale 1ns/10ps

module fpRegFile (
  input  logic             clk,
  input  logic             rst,
  input  fpuPkg::regAddr_t rs1,
  input  fpuPkg::regAddr_t rs2,
  output fpuPkg::fpWord_t  rd1E,
  output fpuPkg::fpWord_t  rd2E,
  input  logic             wbWrite,
  input  fpuPkg::regAddr_t wbAddr,
  input  fpuPkg::fpWord_t  wbData
);

  fpuPkg::fpWord_t regs [32];

  // Storage, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wbWrite) begin
      regs[wbAddr] <= wbData;
    end
  end

  // Read ports into execute, write-through on address match
  always_ff @(posedge clk) begin
    if (rst) begin
      rd1E <= '0;
      rd2E <= '0;
    end else begin
      rd1E <= (wbWrite && wbAddr == rs1) ? wbData : regs[rs1];
      rd2E <= (wbWrite && wbAddr == rs2) ? wbData : regs[rs2];
    end
  end

endmodule

// ==== src/fpUnpack.sv ====
// Binary32 only; NaN payload is passed through untouched
`timescale 1ns/10ps

module fpUnpack (
  input  fpuPkg::fpWord_t  value,
  output fpuPkg::fpParts_t parts
);

  logic expMax;    // All ones for inf or NaN
  logic expZero;   // Zero or subnormal
  logic fracZero;

  // Field split
  assign parts.sign = value[fpuPkg::FLEN-1];
  assign parts.exp  = value[fpuPkg::FLEN-2 -: fpuPkg::NE];
  assign parts.frac = value[fpuPkg::NF-1:0];

  assign expMax   = &value[fpuPkg::FLEN-2 -: fpuPkg::NE];
  assign expZero  = ~|value[fpuPkg::FLEN-2 -: fpuPkg::NE];
  assign fracZero = ~|value[fpuPkg::NF-1:0];

  ////////////////////
  // Classification
  ////////////////////
  assign parts.isZero    = expZero & fracZero;
  assign parts.isSubnorm = expZero & ~fracZero;
  assign parts.isInf     = expMax & fracZero;
  assign parts.isNaN     = expMax & ~fracZero;
  assign parts.isSNaN    = expMax & ~fracZero & ~value[fpuPkg::NF-1];   // Quiet bit is frac MSB

endmodule

// ==== src/fpCompare.sv ====
// funct3 meaning depends on caller: 0 min / 1 max for min/max, 0 le / 1 lt / 2 eq for compares
`timescale 1ns/10ps

module fpCompare (
  input  logic [2:0]       funct3,
  input  fpuPkg::fpParts_t x,
  input  fpuPkg::fpParts_t y,
  input  fpuPkg::fpWord_t  xVal,
  input  fpuPkg::fpWord_t  yVal,
  output fpuPkg::fpWord_t  minMaxRes,
  output logic             cmpRes,
  output logic             cmpNV,
  output logic             minMaxNV
);

  logic anyNaN, anySNaN;
  logic bothZero;
  logic eq;           // Numeric equality, +0 == -0
  logic lt;           // Numeric less than, +0 not below -0
  logic ltMinMax;     // Same, but -0 orders below +0
  logic magLt;        // Magnitude of x below y

  assign anyNaN   = x.isNaN | y.isNaN;
  assign anySNaN  = x.isSNaN | y.isSNaN;
  assign bothZero = x.isZero & y.isZero;
  assign magLt    = xVal[fpuPkg::FLEN-2:0] < yVal[fpuPkg::FLEN-2:0];

  ////////////////////
  // Ordering of non-NaN operands
  ////////////////////
  assign eq = (xVal == yVal) | bothZero;

  always_comb begin
    if (x.sign != y.sign)
      lt = x.sign & ~bothZero;                // Negative below positive
    else if (x.sign)
      lt = ~magLt & (xVal != yVal);           // Both negative, bigger magnitude is smaller
    else
      lt = magLt;
  end

  assign ltMinMax = lt | (bothZero & x.sign & ~y.sign);

  // fmin / fmax, NaN loses against a number
  always_comb begin
    if (x.isNaN & y.isNaN)
      minMaxRes = fpuPkg::CANON_NAN;
    else if (x.isNaN)
      minMaxRes = yVal;
    else if (y.isNaN)
      minMaxRes = xVal;
    else if (funct3[0])
      minMaxRes = ltMinMax ? yVal : xVal;     // Max
    else
      minMaxRes = ltMinMax ? xVal : yVal;     // Min
  end

  // feq / flt / fle, unordered is false
  always_comb begin
    case (funct3)
      3'd2:    cmpRes = eq;
      3'd1:    cmpRes = lt;
      3'd0:    cmpRes = lt | eq;
      default: cmpRes = 1'b0;
    endcase
    if (anyNaN) cmpRes = 1'b0;
  end

  // Invalid: feq is quiet, flt/fle are signaling
  assign cmpNV    = (funct3 == 3'd2) ? anySNaN : anyNaN;
  assign minMaxNV = anySNaN;

endmodule

// ==== src/fpExecute.sv ====
// One-cycle execute; forwards only from its own writeback register, which covers every hazard
`timescale 1ns/10ps

module fpExecute (
  input  logic             clk,
  input  logic             rst,
  input  fpuPkg::fpCtrl_t  ctrlE,
  input  logic             illegalE,
  input  fpuPkg::fpWord_t  rd1E,
  input  fpuPkg::fpWord_t  rd2E,
  output logic             wbWrite,
  output fpuPkg::regAddr_t wbAddr,
  output fpuPkg::fpWord_t  wbData,
  output logic             intResValid,
  output fpuPkg::intWord_t intResult,
  output fpuPkg::fflags_t  flags,
  output logic             illegalInstr
);

  fpuPkg::fpWord_t  xE, yE;             // Operands after forwarding
  fpuPkg::fpParts_t xParts, yParts;
  fpuPkg::fpWord_t  sgnRes, minMaxRes, fpRes;
  fpuPkg::intWord_t intRes;
  logic             cmpRes, cmpNV, minMaxNV, nv;
  logic             sgn;                // Injected sign
  logic             xNorm;
  logic [9:0]       classCode;          // One-hot fclass

  ////////////////////
  // Forwarding and unpack
  ////////////////////
  assign xE = (wbWrite && wbAddr == ctrlE.rs1) ? wbData : rd1E;
  assign yE = (wbWrite && wbAddr == ctrlE.rs2) ? wbData : rd2E;

  fpUnpack unpackX (.value(xE), .parts(xParts));
  fpUnpack unpackY (.value(yE), .parts(yParts));

  fpCompare compare (
    .funct3(ctrlE.funct3), .x(xParts), .y(yParts), .xVal(xE), .yVal(yE),
    .minMaxRes, .cmpRes, .cmpNV, .minMaxNV
  );

  // Sign injection, magnitude always from rs1
  always_comb begin
    case (ctrlE.funct3[1:0])
      2'd0:    sgn = yParts.sign;                  // fsgnj
      2'd1:    sgn = ~yParts.sign;                 // fsgnjn
      default: sgn = xParts.sign ^ yParts.sign;    // fsgnjx
    endcase
  end
  assign sgnRes = {sgn, xE[fpuPkg::FLEN-2:0]};

  // fclass bits 0..9
  assign xNorm = ~(xParts.isZero | xParts.isSubnorm | xParts.isInf | xParts.isNaN);
  assign classCode = {
    xParts.isNaN & ~xParts.isSNaN,                 // 9 qNaN
    xParts.isSNaN,                                 // 8 sNaN
    ~xParts.sign & xParts.isInf,                   // 7 +inf
    ~xParts.sign & xNorm,
    ~xParts.sign & xParts.isSubnorm,
    ~xParts.sign & xParts.isZero,                  // 4 +0
    xParts.sign & xParts.isZero,
    xParts.sign & xParts.isSubnorm,
    xParts.sign & xNorm,
    xParts.sign & xParts.isInf                     // 0 -inf
  };

  ////////////////////
  // Result select
  ////////////////////
  always_comb begin
    fpRes  = sgnRes;
    intRes = xE;                                   // fmv.x.w, raw bits
    nv     = 1'b0;
    case (ctrlE.op)
      fpuPkg::OP_MINMAX: begin
        fpRes = minMaxRes;
        nv    = minMaxNV;
      end
      fpuPkg::OP_CMP: begin
        intRes = fpuPkg::intWord_t'(cmpRes);
        nv     = cmpNV;
      end
      fpuPkg::OP_CLASS: intRes = fpuPkg::intWord_t'(classCode);
      fpuPkg::OP_MVWX:  fpRes  = ctrlE.intSrc;
      default: ;                                   // Sign injection and fmv.x.w
    endcase
  end

  // Execute/writeback register
  always_ff @(posedge clk) begin
    if (rst) begin
      wbWrite      <= 1'b0;
      intResValid  <= 1'b0;
      flags        <= '0;
      illegalInstr <= 1'b0;
    end else begin
      wbWrite      <= ctrlE.valid & ctrlE.writesFp;
      intResValid  <= ctrlE.valid & ctrlE.writesInt;
      flags        <= {ctrlE.valid & nv, 4'b0000};   // NV only
      illegalInstr <= illegalE;
    end
  end

  always_ff @(posedge clk) begin
    wbAddr    <= ctrlE.rd;
    wbData    <= fpRes;
    intResult <= intRes;
  end

endmodule

// ==== src/fpu.sv ====
// No handshake and no stalls; each result is valid for exactly one cycle, two edges after issue
`timescale 1ns/10ps

module fpu (
  input  logic             clk,
  input  logic             rst,
  // Issue
  input  logic             instrValid,
  input  fpuPkg::instr_t   instr,
  input  fpuPkg::intWord_t intSrc,        // Integer rs1 value for fmv.w.x
  // Writeback
  output logic             illegalInstr,
  output logic             intResValid,
  output fpuPkg::intWord_t intResult,
  output logic             fpWriteValid,
  output fpuPkg::regAddr_t fpWriteAddr,
  output fpuPkg::fpWord_t  fpWriteData,
  output fpuPkg::fflags_t  flags
);

  fpuPkg::regAddr_t rs1, rs2;             // Decode stage read addresses
  fpuPkg::fpCtrl_t  ctrlE;
  logic             illegalE;
  fpuPkg::fpWord_t  rd1E, rd2E;           // Registered operands

  ////////////////////
  // Decode
  ////////////////////
  fpuDecoder decoder (
    .clk, .rst, .instrValid, .instr, .intSrc,
    .rs1, .rs2, .ctrlE, .illegalE
  );

  // Writeback bus loops back into the register file
  fpRegFile regFile (
    .clk, .rst, .rs1, .rs2, .rd1E, .rd2E,
    .wbWrite(fpWriteValid), .wbAddr(fpWriteAddr), .wbData(fpWriteData)
  );

  ////////////////////
  // Execute and writeback
  ////////////////////
  fpExecute execute (
    .clk, .rst, .ctrlE, .illegalE, .rd1E, .rd2E,
    .wbWrite(fpWriteValid), .wbAddr(fpWriteAddr), .wbData(fpWriteData),
    .intResValid, .intResult, .flags, .illegalInstr
  );

endmodule

// ==== tests/fpuAssertions.sv ====
// Observes top-level ports only, so flag rules are checked against the valid outputs
`timescale 1ns/10ps

module fpuAssertions (
  input logic            clk,
  input logic            rst,
  input logic            intResValid,
  input logic            fpWriteValid,
  input logic            illegalInstr,
  input fpuPkg::fflags_t flags
);

  // A result goes to one destination only
  oneDestination: assert property (@(posedge clk) disable iff (rst)
    !(intResValid && fpWriteValid))
    else $error("intResValid and fpWriteValid high in the same cycle");

  noIllegalWrite: assert property (@(posedge clk) disable iff (rst)
    !(fpWriteValid && illegalInstr))   // Illegal op must not touch the register file
    else $error("FP register write from an illegal instruction");

  // NV needs a legal result, DZ OF UF NX never set
  flagsOnlyNv: assert property (@(posedge clk) disable iff (rst)
    (flags != '0) |-> ((intResValid || fpWriteValid) && flags[3:0] == 4'b0000))
    else $error("Flags raised where NV cannot apply");

endmodule

// ==== tests/fpuTb.sv ====
// Directed tests; each slot is checked two edges after issue, inputs change on falling edges
`timescale 1ns/10ps

module fpuTb;

  typedef enum logic [1:0] {NONE, INTRES, FPWRITE, ILLEGAL} resKind_t;

  typedef struct packed {           // Expected outcome of one issue slot
    resKind_t         kind;
    fpuPkg::regAddr_t addr;
    fpuPkg::fpWord_t  value;
    logic             nv;
  } expResult_t;

  logic             clk, rst, instrValid;
  fpuPkg::instr_t   instr;
  fpuPkg::intWord_t intSrc;
  logic             illegalInstr, intResValid, fpWriteValid;
  fpuPkg::intWord_t intResult;
  fpuPkg::regAddr_t fpWriteAddr;
  fpuPkg::fpWord_t  fpWriteData;
  fpuPkg::fflags_t  flags;

  expResult_t  pending [$];                    // Issued, result not seen yet
  logic [31:0] lfsr = 32'hee28bac8;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycleLimit = 4 * (15 + 22 + 30 + 37 + 22 + 12) + 4;   // Issues per test, reset

  fpu DUT (.*);

  bind fpu fpuAssertions assertions (.clk, .rst, .intResValid, .fpWriteValid,
    .illegalInstr, .flags);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Stimulus and reference rules
  ////////////////////
  function automatic logic nextRandBit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);   // Galois taps 32,22,2,1
    return b;
  endfunction

  function automatic fpuPkg::fpWord_t randomWord();
    fpuPkg::fpWord_t w;
    for (int i = 0; i < 32; i++) begin
      w[i] = nextRandBit();
    end
    return w;
  endfunction

  function automatic fpuPkg::instr_t opFp(logic [6:0] f7, fpuPkg::regAddr_t rs2,
      fpuPkg::regAddr_t rs1, logic [2:0] f3, fpuPkg::regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, fpuPkg::OP_FP};
  endfunction

  function automatic expResult_t slot(resKind_t k, fpuPkg::regAddr_t a, fpuPkg::fpWord_t v,
      logic nv);
    return '{kind: k, addr: a, value: v, nv: nv};
  endfunction

  function automatic logic isNaN(fpuPkg::fpWord_t v);
    return (v[30:23] == 8'hFF) && (v[22:0] != 23'd0);
  endfunction

  function automatic logic isSNaN(fpuPkg::fpWord_t v);
    return isNaN(v) && !v[22];                          // Quiet bit clear
  endfunction

  // Monotonic key over all non-NaN values, -0 just below +0
  function automatic logic [31:0] orderKey(fpuPkg::fpWord_t v);
    return v[31] ? ~v : {1'b1, v[30:0]};
  endfunction

  function automatic fpuPkg::fpWord_t minMaxRef(fpuPkg::fpWord_t a, fpuPkg::fpWord_t b,
      logic isMax);
    logic aBelow;
    aBelow = orderKey(a) < orderKey(b);
    if (isNaN(a) && isNaN(b)) return fpuPkg::CANON_NAN;
    if (isNaN(a)) return b;
    if (isNaN(b)) return a;
    return (aBelow ^ isMax) ? a : b;
  endfunction

  function automatic logic cmpRef(fpuPkg::fpWord_t a, fpuPkg::fpWord_t b, logic [2:0] f3);
    logic eq, lt;
    eq = (a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0));   // +0 equals -0
    lt = !eq && (orderKey(a) < orderKey(b));
    if (isNaN(a) || isNaN(b)) return 1'b0;              // Unordered
    return (f3 == 3'd2) ? eq : (f3 == 3'd1) ? lt : (lt || eq);
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic checkBit(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkInt(fpuPkg::intWord_t got, fpuPkg::intWord_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: intResult is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkFp(fpuPkg::regAddr_t gotAddr, fpuPkg::fpWord_t gotData,
      fpuPkg::regAddr_t expAddr, fpuPkg::fpWord_t expData);
    checks++;
    if (gotAddr !== expAddr || gotData !== expData) begin
      errors++;
      $display("ERROR %0t: FP write f%0d = %h, expected f%0d = %h", $time, gotAddr,
        gotData, expAddr, expData);
    end
  endtask

  task automatic checkFlags(fpuPkg::fflags_t got, fpuPkg::fflags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: flags are %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic checkSlot(expResult_t e);
    checkBit(illegalInstr, e.kind == ILLEGAL, "illegalInstr");
    checkBit(intResValid, e.kind == INTRES, "intResValid");
    checkBit(fpWriteValid, e.kind == FPWRITE, "fpWriteValid");
    checkFlags(flags, {e.nv, 4'b0000});                  // Only NV can rise
    if (e.kind == INTRES) checkInt(intResult, e.value);
    if (e.kind == FPWRITE) checkFp(fpWriteAddr, fpWriteData, e.addr, e.value);
  endtask

  // Drive at a falling edge, then check the slot issued one cycle earlier
  task automatic issue(logic valid, fpuPkg::instr_t ins, fpuPkg::intWord_t src,
      expResult_t e);
    instrValid = valid;
    instr = ins;
    intSrc = src;
    pending.push_back(e);
    @(negedge clk);
    if (pending.size() == 2) checkSlot(pending.pop_front());
  endtask

  task automatic loadReg(fpuPkg::regAddr_t rd, fpuPkg::fpWord_t v);
    issue(1'b1, opFp(fpuPkg::F7_MVWX, 5'd0, 5'd0, 3'd0, rd), v, slot(FPWRITE, rd, v, 1'b0));
  endtask

  task automatic readReg(fpuPkg::regAddr_t rs1, fpuPkg::fpWord_t v);
    issue(1'b1, opFp(fpuPkg::F7_MVXCLASS, 5'd0, rs1, 3'd0, 5'd1), '0,
      slot(INTRES, 5'd0, v, 1'b0));
  endtask

  task automatic bubbles();
    repeat (2) issue(1'b0, '0, '0, slot(NONE, 5'd0, '0, 1'b0));   // Flush the pipe
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic testMoves();
    fpuPkg::fpWord_t vals [4];
    for (int i = 0; i < 4; i++) begin
      vals[i] = randomWord();
      loadReg(fpuPkg::regAddr_t'(i + 1), vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      readReg(fpuPkg::regAddr_t'(i + 1), vals[i]);
    end
    vals[0] = randomWord();
    loadReg(5'd5, vals[0]);
    readReg(5'd5, vals[0]);               // Forwarded from writeback
    vals[1] = randomWord();
    loadReg(5'd6, vals[1]);
    loadReg(5'd7, vals[0]);
    readReg(5'd6, vals[1]);               // Register file write-through
    bubbles();
  endtask

  task automatic testSignInject();
    fpuPkg::fpWord_t a, b;
    logic s;
    for (int i = 0; i < 4; i++) begin
      a = randomWord();
      b = randomWord();
      loadReg(5'd8, a);
      loadReg(5'd9, b);
      for (int f = 0; f < 3; f++) begin
        s = (f == 0) ? b[31] : (f == 1) ? !b[31] : (a[31] ^ b[31]);
        issue(1'b1, opFp(fpuPkg::F7_SGNJ, 5'd9, 5'd8, 3'(f), 5'd10), '0,
          slot(FPWRITE, 5'd10, {s, a[30:0]}, 1'b0));
      end
    end
    bubbles();
  endtask

  task automatic testMinMax();
    fpuPkg::fpWord_t xs [7] = '{32'h00000000, 32'h80000000, 32'h7FC00000, 32'h40000000,
                               32'h7FC00000, 32'h3FC00000, 32'hC0400000};
    fpuPkg::fpWord_t ys [7] = '{32'h80000000, 32'h00000000, 32'h3F800000, 32'h7F800001,
                               32'hFF800001, 32'hC0400000, 32'hC0000000};
    logic nv;
    for (int i = 0; i < 7; i++) begin
      loadReg(5'd11, xs[i]);
      loadReg(5'd12, ys[i]);
      nv = isSNaN(xs[i]) || isSNaN(ys[i]);              // Quiet NaN alone is not invalid
      for (int f = 0; f < 2; f++) begin
        issue(1'b1, opFp(fpuPkg::F7_MINMAX, 5'd12, 5'd11, 3'(f), 5'd13), '0,
          slot(FPWRITE, 5'd13, minMaxRef(xs[i], ys[i], f == 1), nv));
      end
    end
    bubbles();
  endtask

  task automatic testCompare();
    fpuPkg::fpWord_t xs [7] = '{32'h3F800000, 32'h40000000, 32'h3F800000, 32'h00000000,
                               32'hBF800000, 32'h7FC00000, 32'h3F800000};
    fpuPkg::fpWord_t ys [7] = '{32'h40000000, 32'h3F800000, 32'h3F800000, 32'h80000000,
                               32'h3F800000, 32'h3F800000, 32'h7F800001};
    logic nv;
    for (int i = 0; i < 7; i++) begin
      loadReg(5'd14, xs[i]);
      loadReg(5'd15, ys[i]);
      for (int f = 0; f < 3; f++) begin
        nv = (f == 2) ? (isSNaN(xs[i]) || isSNaN(ys[i])) : (isNaN(xs[i]) || isNaN(ys[i]));
        issue(1'b1, opFp(fpuPkg::F7_CMP, 5'd15, 5'd14, 3'(f), 5'd2), '0,
          slot(INTRES, 5'd0, fpuPkg::intWord_t'(cmpRef(xs[i], ys[i], 3'(f))), nv));
      end
    end
    bubbles();
  endtask

  task automatic testClassify();
    fpuPkg::fpWord_t vals [10] = '{32'hFF800000, 32'hBF800000, 32'h80000001, 32'h80000000,
                                  32'h00000000, 32'h00000001, 32'h3F800000, 32'h7F800000,
                                  32'h7F800001, 32'h7FC00000};
    for (int i = 0; i < 10; i++) begin
      loadReg(5'd16, vals[i]);
      issue(1'b1, opFp(fpuPkg::F7_MVXCLASS, 5'd0, 5'd16, 3'd1, 5'd3), '0,
        slot(INTRES, 5'd0, fpuPkg::intWord_t'(1) << i, 1'b0));   // Bit i in list order
    end
    bubbles();
  endtask

  task automatic testIllegal();
    fpuPkg::instr_t  bad [8];
    fpuPkg::fpWord_t keep;
    bad[0] = {fpuPkg::F7_SGNJ, 5'd9, 5'd8, 3'd0, 5'd17, 7'b0000111};   // FP load opcode
    bad[1] = opFp(fpuPkg::F7_SGNJ, 5'd9, 5'd8, 3'd3, 5'd17);
    bad[2] = opFp(fpuPkg::F7_MINMAX, 5'd9, 5'd8, 3'd2, 5'd17);
    bad[3] = opFp(fpuPkg::F7_CMP, 5'd9, 5'd8, 3'd3, 5'd17);
    bad[4] = opFp(fpuPkg::F7_MVXCLASS, 5'd0, 5'd8, 3'd2, 5'd17);
    bad[5] = opFp(fpuPkg::F7_MVXCLASS, 5'd1, 5'd8, 3'd0, 5'd17);       // rs2 on fmv.x.w
    bad[6] = opFp(fpuPkg::F7_MVWX, 5'd3, 5'd0, 3'd0, 5'd17);
    bad[7] = opFp(7'b0000000, 5'd9, 5'd8, 3'd0, 5'd17);                // fadd.s
    keep = randomWord();
    loadReg(5'd17, keep);
    for (int i = 0; i < 8; i++) begin
      issue(1'b1, bad[i], ~keep, slot(ILLEGAL, 5'd0, '0, 1'b0));
    end
    readReg(5'd17, keep);                 // Still the old value
    bubbles();
  endtask

  initial begin
    rst = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    intSrc = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testMoves();
    testSignInject();
    testMinMax();
    testCompare();
    testClassify();
    testIllegal();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
src/fpuPkg.sv
src/fpuDecoder.sv
src/fpRegFile.sv
src/fpUnpack.sv
src/fpCompare.sv
src/fpExecute.sv
src/fpu.sv
tests/fpuAssertions.sv
tests/fpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run, the pass line in the output decides the exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module fpuTb &&
./obj_dir/VfpuTb | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
